/* logic/uart_pkg.sv */
// uart package: register map, status and control bits, fifo depths, bit period, rx payload
`default_nettype none

package uart_pkg;

  // register addresses on the 2-bit bus
  localparam logic [1:0] ADDR_DATA   = 2'd0;
  localparam logic [1:0] ADDR_STATUS = 2'd1;
  localparam logic [1:0] ADDR_CTRL   = 2'd2;

  // status word bit positions
  localparam int ST_TX_FULL   = 0;
  localparam int ST_TX_EMPTY  = 1;
  localparam int ST_RX_EMPTY  = 2;
  localparam int ST_RX_FULL   = 3;
  localparam int ST_ERR       = 4;
  localparam int ST_FRAME_ERR = 5;

  // rx occupancy field starts here
  localparam int ST_RX_OCUP_LSB = 8;

  // control word bit positions
  localparam int CTRL_CLEAR  = 0;
  localparam int CTRL_IRQ_EN = 1;

  // fifo slot counts, powers of two
  localparam int TX_DEPTH = 4;
  localparam int RX_DEPTH = 4;

  // width of the rx occupancy field, counts 0 to RX_DEPTH
  localparam int RX_OCUP_W = $clog2(RX_DEPTH) + 1;

  // clock cycles per serial bit
  localparam int CLKS_PER_BIT = 8;

  // rx fifo payload
  typedef struct packed {
    logic       frame_err;
    logic [7:0] data;
  } rx_frame_t;

endpackage

`default_nettype wire

/* logic/fifo_if.sv */
// fifo access interface with writer, reader and fifo modports
`timescale 1ns/1ps
`default_nettype none

interface fifo_if #(
  parameter int  SLOTS = 4,
  parameter type T     = logic [7:0]
) ();

  logic                   write;
  logic                   read;
  T                       wdata;
  T                       rdata;
  logic                   full;
  logic                   empty;
  logic                   error;
  logic [$clog2(SLOTS):0] ocup;

  // producer side
  modport writer (output write, output wdata, input full, input empty, input ocup, input error);

  // consumer side, head data is combinational
  modport reader (output read, input rdata, input full, input empty, input ocup, input error);

  // storage side
  modport fifo (input write, input read, input wdata,
                output rdata, output full, output empty, output ocup, output error);

endinterface

`default_nettype wire

/* logic/fifo.sv */
// synchronous fifo with combinational head, clear, error, full, empty and occupancy
`timescale 1ns/1ps
`default_nettype none

module fifo #(
  parameter int  SLOTS = 4,
  parameter type T     = logic [7:0]
) (
  input  logic clk,
  input  logic rst_n_i,
  input  logic clear_i,
  fifo_if.fifo q
);

  localparam int PW = $clog2(SLOTS);

  T            mem [SLOTS];
  logic [PW:0] wr_ptr;
  logic [PW:0] rd_ptr;
  logic [PW:0] wr_ptr_nxt;
  logic [PW:0] rd_ptr_nxt;
  logic [PW:0] count;
  logic        full;
  logic        empty;

  // pointers carry an extra wrap bit to tell full from empty
  assign count = wr_ptr - rd_ptr;
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[PW-1:0] == rd_ptr[PW-1:0]) && (wr_ptr[PW] != rd_ptr[PW]);

  always_comb begin
    wr_ptr_nxt = wr_ptr;
    rd_ptr_nxt = rd_ptr;
    if (q.write && !full) begin
      wr_ptr_nxt = wr_ptr + 1'b1;
    end
    if (q.read && !empty) begin
      rd_ptr_nxt = rd_ptr + 1'b1;
    end
    // clear wins over push and pop
    if (clear_i) begin
      wr_ptr_nxt = '0;
      rd_ptr_nxt = '0;
    end
  end

  assign q.full  = full;
  assign q.empty = empty;
  assign q.error = (q.write && full) || (q.read && empty);
  assign q.ocup  = clear_i ? '0 : count;
  // head reads as zero when nothing is stored
  assign q.rdata = (empty || clear_i) ? '0 : mem[rd_ptr[PW-1:0]];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      wr_ptr <= wr_ptr_nxt;
      rd_ptr <= rd_ptr_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (q.write && !full) begin
      mem[wr_ptr[PW-1:0]] <= q.wdata;
    end
  end

  if (SLOTS < 2 || (1 << PW) != SLOTS) begin : g_bad_slots
    $error("fifo SLOTS must be a power of two and at least 2");
  end

  // occupancy never runs past the slot count
  a_ptr_span: assert property (
    @(posedge clk) disable iff (!rst_n_i) count <= (PW+1)'(SLOTS)
  );

endmodule

`default_nettype wire

/* logic/uart_csr.sv */
// uart register block: access decode, fifo push and pop, sticky errors, irq, read data
`timescale 1ns/1ps
`default_nettype none

module uart_csr
  import uart_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic [1:0]  addr_i,
  input  logic        wr_en_i,
  input  logic        rd_en_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] rdata_o,
  output logic        irq_o,
  fifo_if.writer      tx_q,
  fifo_if.reader      rx_q,
  output logic        clear_o
);

  logic        data_wr;
  logic        data_rd;
  logic        ctrl_wr;
  logic        err_q;
  logic        frame_err_q;
  logic        irq_en_q;
  logic [31:0] status;
  logic [31:0] ctrl_word;
  rx_frame_t   rx_head;

  // access decode
  assign data_wr = wr_en_i && (addr_i == ADDR_DATA);
  assign data_rd = rd_en_i && (addr_i == ADDR_DATA);
  assign ctrl_wr = wr_en_i && (addr_i == ADDR_CTRL);

  assign tx_q.write = data_wr;
  assign tx_q.wdata = wdata_i[7:0];
  assign rx_q.read  = data_rd;
  assign rx_head    = rx_q.rdata;

  // one-cycle clear for both fifos and the sticky flags
  assign clear_o = ctrl_wr && wdata_i[CTRL_CLEAR];

  always_comb begin
    status = '0;
    status[ST_TX_FULL]   = tx_q.full;
    status[ST_TX_EMPTY]  = tx_q.empty;
    status[ST_RX_EMPTY]  = rx_q.empty;
    status[ST_RX_FULL]   = rx_q.full;
    status[ST_ERR]       = err_q;
    status[ST_FRAME_ERR] = frame_err_q;
    status[ST_RX_OCUP_LSB +: RX_OCUP_W] = rx_q.ocup;
  end

  always_comb begin
    ctrl_word = '0;
    ctrl_word[CTRL_IRQ_EN] = irq_en_q;
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      err_q       <= 1'b0;
      frame_err_q <= 1'b0;
      irq_en_q    <= 1'b0;
      irq_o       <= 1'b0;
      rdata_o     <= '0;
    end else begin
      if (clear_o) begin
        err_q       <= 1'b0;
        frame_err_q <= 1'b0;
      end else begin
        // overflow on either side or rx underflow
        if (tx_q.error || rx_q.error) begin
          err_q <= 1'b1;
        end
        // head is zero when empty, so an empty pop never sets this
        if (data_rd && rx_head.frame_err) begin
          frame_err_q <= 1'b1;
        end
      end
      if (ctrl_wr) begin
        irq_en_q <= wdata_i[CTRL_IRQ_EN];
      end
      irq_o <= irq_en_q && !rx_q.empty;
      if (rd_en_i) begin
        case (addr_i)
          ADDR_DATA:   rdata_o <= {24'd0, rx_head.data};
          ADDR_STATUS: rdata_o <= status;
          ADDR_CTRL:   rdata_o <= ctrl_word;
          default:     rdata_o <= '0;
        endcase
      end
    end
  end

  // bus master never reads and writes together
  a_no_rd_wr: assert property (
    @(posedge clk) disable iff (!rst_n_i) !(rd_en_i && wr_en_i)
  );

  a_clear_pulse: assert property (
    @(posedge clk) disable iff (!rst_n_i) clear_o |=> !clear_o
  );

endmodule

`default_nettype wire

/* logic/uart_tx.sv */
// uart transmitter: pops the tx fifo and sends 8N1 frames
`timescale 1ns/1ps
`default_nettype none

module uart_tx
  import uart_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n_i,
  fifo_if.reader q,
  output logic   tx_o
);

  localparam int            CW       = $clog2(CLKS_PER_BIT);
  localparam logic [CW-1:0] CNT_LAST = CW'(CLKS_PER_BIT - 1);

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

  tx_state_t     state;
  logic [CW-1:0] cnt;
  logic [2:0]    bit_idx;
  logic [7:0]    shift;

  // pop only between frames
  assign q.read = (state == TX_IDLE) && !q.empty;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state   <= TX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      tx_o    <= 1'b1;
    end else begin
      case (state)
        TX_IDLE: begin
          cnt     <= '0;
          bit_idx <= '0;
          if (!q.empty) begin
            state <= TX_START;
            tx_o  <= 1'b0;
          end
        end
        TX_START: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_LAST) begin
            state <= TX_DATA;
            tx_o  <= shift[0];
          end
        end
        TX_DATA: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_LAST) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= TX_STOP;
              tx_o  <= 1'b1;
            end else begin
              // lsb first, next bit sits at position 1
              tx_o <= shift[1];
            end
          end
        end
        default: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_LAST) begin
            state <= TX_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (q.read) begin
      shift <= q.rdata;
    end else if (state == TX_DATA && cnt == CNT_LAST) begin
      shift <= {1'b0, shift[7:1]};
    end
  end

  // line idles high between frames
  a_idle_high: assert property (
    @(posedge clk) disable iff (!rst_n_i) (state == TX_IDLE) |-> tx_o
  );

endmodule

`default_nettype wire

/* logic/uart_rx.sv */
// uart receiver: start search, mid-bit sampling, framing check, push into the rx fifo
`timescale 1ns/1ps
`default_nettype none

module uart_rx
  import uart_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n_i,
  input  logic   rx_i,
  fifo_if.writer q
);

  localparam int            CW       = $clog2(CLKS_PER_BIT);
  localparam logic [CW-1:0] CNT_LAST = CW'(CLKS_PER_BIT - 1);
  localparam logic [CW-1:0] CNT_HALF = CW'(CLKS_PER_BIT / 2 - 1);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  rx_state_t     state;
  logic [CW-1:0] cnt;
  logic [2:0]    bit_idx;
  logic          rx_meta;
  logic          rx_sync;
  logic          rx_prev;
  logic [7:0]    shift;
  rx_frame_t     frame;

  // two-flop synchronizer plus one stage for edge detect
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state   <= RX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
    end else begin
      case (state)
        RX_IDLE: begin
          cnt     <= '0;
          bit_idx <= '0;
          if (rx_prev && !rx_sync) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_HALF) begin
            // glitch if the line is high again mid start bit
            cnt   <= '0;
            state <= rx_sync ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_LAST) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end
        end
        default: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_LAST) begin
            state <= RX_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == RX_DATA && cnt == CNT_LAST) begin
      shift <= {rx_sync, shift[7:1]};
    end
  end

  // push at the stop bit middle, low stop means framing error
  assign frame.frame_err = !rx_sync;
  assign frame.data      = shift;
  assign q.wdata         = frame;
  assign q.write         = (state == RX_STOP) && (cnt == CNT_LAST);

  a_one_push: assert property (
    @(posedge clk) disable iff (!rst_n_i) q.write |=> !q.write
  );

endmodule

`default_nettype wire

/* logic/uart_top.sv */
// uart top: register block, tx and rx fifos, transmitter and receiver
`timescale 1ns/1ps
`default_nettype none

module uart_top
  import uart_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic [1:0]  addr_i,
  input  logic        wr_en_i,
  input  logic        rd_en_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] rdata_o,
  output logic        tx_o,
  input  logic        rx_i,
  output logic        irq_o
);

  logic fifo_clear;

  // byte queue towards the line, frame queue from it
  fifo_if #(.SLOTS(TX_DEPTH), .T(logic [7:0])) tx_q ();
  fifo_if #(.SLOTS(RX_DEPTH), .T(rx_frame_t))  rx_q ();

  uart_csr u_csr (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .addr_i  (addr_i),
    .wr_en_i (wr_en_i),
    .rd_en_i (rd_en_i),
    .wdata_i (wdata_i),
    .rdata_o (rdata_o),
    .irq_o   (irq_o),
    .tx_q    (tx_q.writer),
    .rx_q    (rx_q.reader),
    .clear_o (fifo_clear)
  );

  fifo #(.SLOTS(TX_DEPTH), .T(logic [7:0])) u_tx_fifo (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .clear_i (fifo_clear),
    .q       (tx_q.fifo)
  );

  fifo #(.SLOTS(RX_DEPTH), .T(rx_frame_t)) u_rx_fifo (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .clear_i (fifo_clear),
    .q       (rx_q.fifo)
  );

  uart_tx u_tx (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .q       (tx_q.reader),
    .tx_o    (tx_o)
  );

  uart_rx u_rx (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .rx_i    (rx_i),
    .q       (rx_q.writer)
  );

endmodule

`default_nettype wire

/* testbench/tb_uart_top.sv */
// testbench for uart_top: clock, reset, serial loopback, register table, checks, watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_uart_top import uart_pkg::*; ();

  localparam int          CLK_NS     = 20;
  localparam int          N_BYTES    = 13;
  localparam int          POLL_LIMIT = (RX_DEPTH + 2) * 10 * CLKS_PER_BIT;
  localparam logic [31:0] ALL        = 32'hffff_ffff;

  // row kinds
  localparam logic [2:0] K_WR   = 3'd0;
  localparam logic [2:0] K_RD   = 3'd1;
  localparam logic [2:0] K_POLL = 3'd2;
  localparam logic [2:0] K_IDLE = 3'd3;
  localparam logic [2:0] K_IRQ  = 3'd4;
  localparam logic [2:0] K_TX   = 3'd5;

  typedef struct packed {
    logic [2:0]  kind;
    logic [1:0]  addr;
    logic [31:0] data;
    logic [31:0] exp;
    logic [31:0] mask;
  } row_t;

  logic        clk;
  logic        rst_n_i;
  logic [1:0]  addr_i;
  logic        wr_en_i;
  logic        rd_en_i;
  logic [31:0] wdata_i;
  logic [31:0] rdata_o;
  logic        tx_line;
  logic        irq_o;

  row_t       rows[$];
  logic [7:0] tx_bytes [N_BYTES];
  int         data_writes;
  int         idle_cycles;
  int         limit_ns;

  // serial line looped back onto the receiver
  uart_top DUT (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .addr_i  (addr_i),
    .wr_en_i (wr_en_i),
    .rd_en_i (rd_en_i),
    .wdata_i (wdata_i),
    .rdata_o (rdata_o),
    .tx_o    (tx_line),
    .rx_i    (tx_line),
    .irq_o   (irq_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic compare(input string name, input logic [31:0] act, input logic [31:0] exp,
                         input logic [31:0] mask);
    if ((act & mask) !== (exp & mask)) begin
      abort_run($sformatf("MISMATCH time %0d ns: %s is %h, expected %h", $time, name,
                          act & mask, exp & mask));
    end
  endtask

  // expected status word built from the register map
  function automatic logic [31:0] status_word(input logic tx_full, input logic tx_empty,
                                              input logic rx_empty, input logic rx_full,
                                              input logic err, input int ocup);
    logic [31:0] w;
    w = '0;
    w[ST_TX_FULL]  = tx_full;
    w[ST_TX_EMPTY] = tx_empty;
    w[ST_RX_EMPTY] = rx_empty;
    w[ST_RX_FULL]  = rx_full;
    w[ST_ERR]      = err;
    w[ST_RX_OCUP_LSB +: RX_OCUP_W] = RX_OCUP_W'(ocup);
    return w;
  endfunction

  // tasks start and end on a falling edge
  task automatic bus_write(input logic [1:0] addr, input logic [31:0] data);
    addr_i  = addr;
    wdata_i = data;
    wr_en_i = 1'b1;
    @(negedge clk);
    wr_en_i = 1'b0;
  endtask

  task automatic bus_read(input logic [1:0] addr, output logic [31:0] data);
    addr_i  = addr;
    rd_en_i = 1'b1;
    @(negedge clk);
    rd_en_i = 1'b0;
    data    = rdata_o;
  endtask

  task automatic wait_status(input logic [31:0] exp, input logic [31:0] mask);
    logic [31:0] rd;
    int          polls;
    polls = 0;
    bus_read(ADDR_STATUS, rd);
    while (((rd & mask) !== exp) && (polls < POLL_LIMIT)) begin
      bus_read(ADDR_STATUS, rd);
      polls++;
    end
    if ((rd & mask) !== exp) begin
      abort_run($sformatf("status never reached %h under mask %h within %0d polls",
                          exp, mask, polls));
    end
  endtask

  task automatic add_row(input logic [2:0] kind, input logic [1:0] addr,
                         input logic [31:0] data, input logic [31:0] exp,
                         input logic [31:0] mask);
    row_t r;
    r.kind = kind;
    r.addr = addr;
    r.data = data;
    r.exp  = exp;
    r.mask = mask;
    if (kind == K_WR && addr == ADDR_DATA) begin
      data_writes++;
    end
    if (kind == K_IDLE) begin
      idle_cycles += int'(data);
    end
    rows.push_back(r);
  endtask

  task automatic build_table();
    logic [31:0] ocup_mask;
    logic [31:0] st_idle;
    ocup_mask = ((32'd1 << RX_OCUP_W) - 32'd1) << ST_RX_OCUP_LSB;
    st_idle   = status_word(1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 0);
    // state after reset
    add_row(K_TX, ADDR_DATA, 32'd0, 32'd1, 32'd1);
    add_row(K_IRQ, ADDR_DATA, 32'd0, 32'd0, 32'd1);
    add_row(K_RD, ADDR_STATUS, 32'd0, st_idle, ALL);
    // three bytes through the loopback, read back in order
    for (int i = 0; i < 3; i++) begin
      add_row(K_WR, ADDR_DATA, {24'd0, tx_bytes[i]}, 32'd0, 32'd0);
    end
    add_row(K_POLL, ADDR_STATUS, 32'd0, 32'd3 << ST_RX_OCUP_LSB, ocup_mask);
    add_row(K_RD, ADDR_STATUS, 32'd0, status_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 3), ALL);
    for (int i = 0; i < 3; i++) begin
      add_row(K_RD, ADDR_DATA, 32'd0, {24'd0, tx_bytes[i]}, ALL);
    end
    add_row(K_RD, ADDR_STATUS, 32'd0, st_idle, ALL);
    // underflow on an empty rx fifo
    add_row(K_RD, ADDR_DATA, 32'd0, 32'd0, ALL);
    add_row(K_RD, ADDR_STATUS, 32'd0, status_word(1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 0), ALL);
    add_row(K_WR, ADDR_CTRL, 32'd1 << CTRL_CLEAR, 32'd0, 32'd0);
    add_row(K_RD, ADDR_STATUS, 32'd0, st_idle, ALL);
    // burst of writes overruns the tx fifo
    for (int i = 3; i < 3 + 2 * TX_DEPTH; i++) begin
      add_row(K_WR, ADDR_DATA, {24'd0, tx_bytes[i]}, 32'd0, 32'd0);
    end
    add_row(K_RD, ADDR_STATUS, 32'd0, (32'd1 << ST_TX_FULL) | (32'd1 << ST_ERR),
            (32'd1 << ST_TX_FULL) | (32'd1 << ST_ERR));
    add_row(K_POLL, ADDR_STATUS, 32'd0, 32'd1 << ST_RX_FULL, 32'd1 << ST_RX_FULL);
    // let the last accepted frame land on the full rx fifo
    add_row(K_IDLE, ADDR_DATA, 32'(14 * CLKS_PER_BIT), 32'd0, 32'd0);
    add_row(K_RD, ADDR_STATUS, 32'd0,
            status_word(1'b0, 1'b1, 1'b0, 1'b1, 1'b1, RX_DEPTH), ALL);
    add_row(K_RD, ADDR_DATA, 32'd0, {24'd0, tx_bytes[3]}, ALL);
    // clear with data still queued
    add_row(K_WR, ADDR_CTRL, 32'd1 << CTRL_CLEAR, 32'd0, 32'd0);
    add_row(K_RD, ADDR_STATUS, 32'd0, st_idle, ALL);
    add_row(K_RD, ADDR_DATA, 32'd0, 32'd0, ALL);
    add_row(K_WR, ADDR_CTRL, 32'd1 << CTRL_CLEAR, 32'd0, 32'd0);
    // interrupt with the enable set, then cleared
    add_row(K_WR, ADDR_CTRL, 32'd1 << CTRL_IRQ_EN, 32'd0, 32'd0);
    add_row(K_RD, ADDR_CTRL, 32'd0, 32'd1 << CTRL_IRQ_EN, ALL);
    add_row(K_IRQ, ADDR_DATA, 32'd0, 32'd0, 32'd1);
    add_row(K_WR, ADDR_DATA, {24'd0, tx_bytes[11]}, 32'd0, 32'd0);
    add_row(K_POLL, ADDR_STATUS, 32'd0, 32'd0, 32'd1 << ST_RX_EMPTY);
    add_row(K_IRQ, ADDR_DATA, 32'd0, 32'd1, 32'd1);
    add_row(K_RD, ADDR_DATA, 32'd0, {24'd0, tx_bytes[11]}, ALL);
    add_row(K_IRQ, ADDR_DATA, 32'd0, 32'd0, 32'd1);
    add_row(K_WR, ADDR_CTRL, 32'd0, 32'd0, 32'd0);
    add_row(K_WR, ADDR_DATA, {24'd0, tx_bytes[12]}, 32'd0, 32'd0);
    add_row(K_POLL, ADDR_STATUS, 32'd0, 32'd0, 32'd1 << ST_RX_EMPTY);
    add_row(K_IRQ, ADDR_DATA, 32'd0, 32'd0, 32'd1);
    add_row(K_RD, ADDR_DATA, 32'd0, {24'd0, tx_bytes[12]}, ALL);
    add_row(K_RD, ADDR_STATUS, 32'd0, st_idle, ALL);
  endtask

  task automatic run_row(input row_t r);
    logic [31:0] rd;
    case (r.kind)
      K_WR: bus_write(r.addr, r.data);
      K_RD: begin
        bus_read(r.addr, rd);
        compare("rdata_o", rd, r.exp, r.mask);
      end
      K_POLL: wait_status(r.exp, r.mask);
      K_IDLE: repeat (r.data) @(negedge clk);
      K_IRQ: begin
        @(negedge clk);
        compare("irq_o", {31'd0, irq_o}, r.exp, r.mask);
      end
      default: begin
        @(negedge clk);
        compare("tx_o", {31'd0, tx_line}, r.exp, r.mask);
      end
    endcase
  endtask

  // watchdog sized from the frame count and the table length
  initial begin
    wait (limit_ns > 0);
    #(limit_ns);
    abort_run($sformatf("timeout: register table not finished after %0d ns", limit_ns));
  end

  initial begin
    rst_n_i = 1'b0;
    addr_i  = '0;
    wr_en_i = 1'b0;
    rd_en_i = 1'b0;
    wdata_i = '0;
    void'($urandom(96));
    for (int i = 0; i < N_BYTES; i++) begin
      tx_bytes[i] = 8'($urandom());
    end
    build_table();
    limit_ns = ((data_writes + 4) * 10 * CLKS_PER_BIT + 4 * rows.size() + idle_cycles + 8)
               * CLK_NS;
    repeat (8) @(negedge clk);
    rst_n_i = 1'b1;
    foreach (rows[i]) begin
      run_row(rows[i]);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* uart.f */
logic/uart_pkg.sv
logic/fifo_if.sv
logic/fifo.sv
logic/uart_csr.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_top.sv
testbench/tb_uart_top.sv

/* Makefile */
TOP = tb_uart_top

sim:
	verilator --binary --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f uart.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean
